/* rtl/decoder_ctrl_pkg.sv */
`default_nettype none

package decoder_ctrl_pkg;

    // decoding stages seen by the graph
    typedef enum logic [3:0] {
        STAGE_IDLE                  = 4'd0,
        STAGE_MEASUREMENT_LOADING   = 4'd1,
        STAGE_GROW                  = 4'd2,
        STAGE_MERGE                 = 4'd3,
        STAGE_PEELING               = 4'd4,
        STAGE_RESULT_VALID          = 4'd5,
        STAGE_PARAMETERS_LOADING    = 4'd6,
        STAGE_MEASUREMENT_PREPARING = 4'd7
    } stage_t;

    typedef enum logic [7:0] {
        HEADER_INITIALIZE_DECODING = 8'h00,
        HEADER_DECODE_BLOCK        = 8'h01,
        HEADER_RESULT              = 8'h02
    } header_t;

    // payload bit 0 is peel-and-finish on decode, bits 15:0 the cycle count on result
    typedef struct packed {
        logic [7:0]  dest;
        header_t     header;
        logic [47:0] payload;
    } ctrl_msg_t;

    localparam int GRID_WIDTH_X = 4;
    localparam int GRID_WIDTH_Z = 1;
    localparam int GRID_WIDTH_U = 3;

    localparam logic [31:0] END_MARKER = 32'hffff_ffff;

    // at least one bit, also for a grid width of one
    function automatic int field_bits(input int width);
        return (width > 1) ? $clog2(width) : 1;
    endfunction

    // north-south, east-west and up-down edges of one round
    function automatic int correction_bits(input int gx, input int gz);
        return (gx - 1) * gz + (gx - 1) * gz + 1 + gx * gz;
    endfunction

    // result word, whole bytes and wide enough for the summary word
    function automatic int result_bits(input int gx, input int gz);
        int padded;
        padded = (correction_bits(gx, gz) + 7) / 8 * 8;
        return (padded > 32) ? padded : 32;
    endfunction

endpackage

`default_nettype wire

/* rtl/measurement_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module measurement_loader
    import decoder_ctrl_pkg::*;
#(
    parameter int GRID_WIDTH_X = decoder_ctrl_pkg::GRID_WIDTH_X,
    parameter int GRID_WIDTH_Z = decoder_ctrl_pkg::GRID_WIDTH_Z,
    parameter int GRID_WIDTH_U = decoder_ctrl_pkg::GRID_WIDTH_U
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  stage_t                               stage,
    input  logic [31:0]                          meas_data,
    input  logic                                 meas_valid,
    output logic                                 meas_ready,
    output logic [GRID_WIDTH_X*GRID_WIDTH_Z-1:0] measurements,
    output logic                                 reset_all_edges,
    output logic                                 load_done
);

    localparam int X_BITS = field_bits(GRID_WIDTH_X);
    localparam int Z_BITS = field_bits(GRID_WIDTH_Z);
    localparam int U_BITS = field_bits(GRID_WIDTH_U);
    localparam int PU_COUNT = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int ADDR_BITS = field_bits(PU_COUNT);

    logic [U_BITS-1:0]    current_round;
    logic [PU_COUNT-1:0]  defect_bits;
    logic [U_BITS-1:0]    word_round;
    logic [X_BITS-1:0]    word_x;
    logic [Z_BITS-1:0]    word_z;
    logic [ADDR_BITS-1:0] address;
    logic                 is_end;
    logic                 loading;
    logic                 last_round;
    logic                 match;
    logic                 advance;

    // word layout is round, x, z from the top down
    assign word_z = meas_data[Z_BITS-1:0];
    assign word_x = meas_data[X_BITS+Z_BITS-1:Z_BITS];
    assign word_round = meas_data[U_BITS+X_BITS+Z_BITS-1:X_BITS+Z_BITS];
    assign address = ADDR_BITS'(word_x * GRID_WIDTH_Z + word_z);
    assign is_end = (meas_data == END_MARKER);

    assign loading = (stage == STAGE_MEASUREMENT_LOADING);
    assign last_round = (current_round == U_BITS'(GRID_WIDTH_U - 1));
    assign match = loading && meas_valid && !is_end && (word_round == current_round);
    // head word belongs to a later round, or is the end marker
    assign advance = loading && meas_valid && !match;

    assign load_done = advance && last_round && is_end;
    assign meas_ready = match || load_done;
    assign reset_all_edges = loading;

    always_ff @(posedge clk) begin
        if (reset) begin
            current_round <= '0;
        end else if (stage == STAGE_MEASUREMENT_PREPARING) begin
            current_round <= '0;
        end else if (advance && !last_round) begin
            current_round <= current_round + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (stage == STAGE_MEASUREMENT_PREPARING) begin
            defect_bits <= '0;
            measurements <= '0;
        end else if (advance) begin
            measurements <= defect_bits;
            defect_bits <= '0;
        end else if (match) begin
            defect_bits[address] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/stage_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_sequencer
    import decoder_ctrl_pkg::*;
#(
    parameter int GRID_WIDTH_X  = decoder_ctrl_pkg::GRID_WIDTH_X,
    parameter int GRID_WIDTH_Z  = decoder_ctrl_pkg::GRID_WIDTH_Z,
    parameter int GRID_WIDTH_U  = decoder_ctrl_pkg::GRID_WIDTH_U,
    parameter int MAXIMUM_DELAY = 3,
    localparam int PE_COUNT     = GRID_WIDTH_X * GRID_WIDTH_Z * GRID_WIDTH_U,
    localparam int CORR_BITS    = correction_bits(GRID_WIDTH_X, GRID_WIDTH_Z),
    localparam int RESULT_BITS  = result_bits(GRID_WIDTH_X, GRID_WIDTH_Z),
    localparam int U_BITS       = field_bits(GRID_WIDTH_U)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrl_msg_t              ctrl_rx,
    input  logic                   ctrl_rx_valid,
    output logic                   ctrl_rx_ready,
    output ctrl_msg_t              ctrl_tx,
    output logic                   ctrl_tx_valid,
    input  logic                   ctrl_tx_ready,
    input  logic                   load_done,
    input  logic [PE_COUNT-1:0]    busy_pe,
    input  logic [PE_COUNT-1:0]    odd_clusters_pe,
    input  logic [CORR_BITS-1:0]   correction,
    output stage_t                 stage,
    output logic [U_BITS-1:0]      result_round,
    output logic [RESULT_BITS-1:0] push_data,
    output logic                   push
);

    localparam int DELAY_BITS = $clog2(MAXIMUM_DELAY + 2);

    stage_t                 stage_d;
    logic                   busy;
    logic                   odd;
    logic                   peel_and_finish;
    logic [DELAY_BITS-1:0]  delay_count;
    logic [7:0]             iteration_count;
    logic [15:0]            cycle_count;
    logic [CORR_BITS-1:0]   correction_q;
    logic [RESULT_BITS-1:0] summary;
    logic                   decode_start;

    assign ctrl_rx_ready = (stage == STAGE_IDLE);
    assign decode_start = ctrl_rx_valid && ctrl_rx_ready
                          && (ctrl_rx.header == HEADER_DECODE_BLOCK);

    // reductions over all PEs, one cycle behind the graph
    always_ff @(posedge clk) begin
        busy <= |busy_pe;
        odd <= |odd_clusters_pe;
        correction_q <= correction;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
            stage_d <= STAGE_IDLE;
            delay_count <= '0;
            result_round <= '0;
            peel_and_finish <= 1'b0;
        end else begin
            stage_d <= stage;
            unique case (stage)
                STAGE_IDLE: begin
                    if (ctrl_rx_valid && ctrl_rx.header == HEADER_INITIALIZE_DECODING) begin
                        stage <= STAGE_PARAMETERS_LOADING;
                    end else if (decode_start) begin
                        stage <= STAGE_MEASUREMENT_PREPARING;
                        peel_and_finish <= ctrl_rx.payload[0];
                    end
                end
                STAGE_PARAMETERS_LOADING: stage <= STAGE_IDLE;
                STAGE_MEASUREMENT_PREPARING: stage <= STAGE_MEASUREMENT_LOADING;
                STAGE_MEASUREMENT_LOADING: begin
                    if (load_done) begin
                        stage <= STAGE_GROW;
                    end
                end
                STAGE_GROW: begin
                    stage <= STAGE_MERGE;
                    delay_count <= '0;
                end
                STAGE_MERGE: begin
                    // let the merge settle before trusting busy
                    if (delay_count < DELAY_BITS'(MAXIMUM_DELAY)) begin
                        delay_count <= delay_count + 1'b1;
                    end else if (!busy) begin
                        if (odd) begin
                            stage <= STAGE_GROW;
                        end else if (peel_and_finish) begin
                            stage <= STAGE_PEELING;
                        end
                    end
                end
                STAGE_PEELING: begin
                    stage <= STAGE_RESULT_VALID;
                    result_round <= '0;
                end
                STAGE_RESULT_VALID: begin
                    result_round <= result_round + 1'b1;
                    if (result_round == U_BITS'(GRID_WIDTH_U - 1)) begin
                        stage <= STAGE_IDLE;
                        result_round <= '0;
                    end
                end
                default: stage <= STAGE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_count <= '0;
            cycle_count <= '0;
        end else if (decode_start) begin
            iteration_count <= '0;
            cycle_count <= 16'd1;
        end else begin
            if (stage == STAGE_GROW) begin
                iteration_count <= iteration_count + 1'b1;
            end
            if (stage inside {STAGE_MEASUREMENT_PREPARING, STAGE_MEASUREMENT_LOADING,
                              STAGE_GROW, STAGE_MERGE, STAGE_PEELING}) begin
                cycle_count <= cycle_count + 1'b1;
            end
        end
    end

    // result message, held until the host takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_tx_valid <= 1'b0;
        end else if (stage == STAGE_PEELING) begin
            ctrl_tx_valid <= 1'b1;
        end else if (ctrl_tx_ready) begin
            ctrl_tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stage == STAGE_PEELING) begin
            ctrl_tx.dest <= 8'h00;
            ctrl_tx.header <= HEADER_RESULT;
            // count as it reads during result_valid, after the peeling cycle
            ctrl_tx.payload <= {32'h0, cycle_count + 16'd1};
        end
    end

    always_comb begin
        summary = '0;
        summary[31:16] = 16'(iteration_count);
        summary[15:0] = cycle_count;
    end

    // summary on the first result cycle, then one correction per round a cycle later
    assign push = (stage == STAGE_RESULT_VALID) || (stage_d == STAGE_RESULT_VALID);
    assign push_data = (stage_d == STAGE_RESULT_VALID) ? RESULT_BITS'(correction_q) : summary;

endmodule

`default_nettype wire

/* rtl/result_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module result_fifo #(
    parameter int WIDTH      = 32,
    parameter int FIFO_DEPTH = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] push_data,
    input  logic             push,
    output logic [WIDTH-1:0] pop_data,
    output logic             pop_valid,
    input  logic             pop_ready
);

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);

    logic [WIDTH-1:0]      mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop_valid = (count != '0);
    assign pop_data = mem[rd_ptr];
    assign pop = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/correction_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

module correction_serializer
    import decoder_ctrl_pkg::*;
#(
    parameter int GRID_WIDTH_U = decoder_ctrl_pkg::GRID_WIDTH_U,
    parameter int WIDTH        = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] pop_data,
    input  logic             pop_valid,
    output logic             pop_ready,
    output logic [31:0]      out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int U_BITS = field_bits(GRID_WIDTH_U);
    localparam int INDEX_BITS = field_bits(GRID_WIDTH_U + 2);
    // bit-in-byte in the low three bits, byte index above it
    localparam int BIT_BITS = $clog2(WIDTH);
    localparam logic [INDEX_BITS-1:0] END_INDEX = INDEX_BITS'(GRID_WIDTH_U + 1);

    // 0 is the summary, 1 to GRID_WIDTH_U the rounds, then the end marker
    logic [INDEX_BITS-1:0] word_index;
    logic [WIDTH-1:0]      pending;
    logic [WIDTH-1:0]      remaining;
    logic [BIT_BITS-1:0]   low_bit;
    logic [U_BITS-1:0]     round;

    function automatic logic [BIT_BITS-1:0] lowest_set(input logic [WIDTH-1:0] value);
        logic [BIT_BITS-1:0] index;
        index = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (value[i]) begin
                index = BIT_BITS'(i);
            end
        end
        return index;
    endfunction

    assign low_bit = lowest_set(pending);
    assign round = U_BITS'(word_index - 1'b1);

    always_comb begin
        remaining = pending;
        remaining[low_bit] = 1'b0;
    end

    always_comb begin
        out_data = '0;
        out_valid = 1'b0;
        pop_ready = 1'b0;
        if (word_index == '0) begin
            out_data = pop_data[31:0];
            out_valid = pop_valid;
            pop_ready = out_ready;
        end else if (word_index == END_INDEX) begin
            out_data = END_MARKER;
            out_valid = 1'b1;
        end else if (|pending) begin
            out_data[U_BITS+BIT_BITS-1:0] = {round, low_bit};
            out_valid = 1'b1;
        end else begin
            // nothing held, fetch the next round
            pop_ready = out_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            word_index <= '0;
            pending <= '0;
        end else if (word_index == '0) begin
            if (pop_valid && pop_ready) begin
                word_index <= word_index + 1'b1;
            end
        end else if (word_index == END_INDEX) begin
            if (out_ready) begin
                word_index <= '0;
            end
        end else if (|pending) begin
            if (out_ready) begin
                pending <= remaining;
                if (remaining == '0) begin
                    word_index <= word_index + 1'b1;
                end
            end
        end else if (pop_valid && pop_ready) begin
            pending <= pop_data;
            // empty round is skipped
            if (pop_data == '0) begin
                word_index <= word_index + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/decoder_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module decoder_ctrl
    import decoder_ctrl_pkg::*;
#(
    parameter int GRID_WIDTH_X  = decoder_ctrl_pkg::GRID_WIDTH_X,
    parameter int GRID_WIDTH_Z  = decoder_ctrl_pkg::GRID_WIDTH_Z,
    parameter int GRID_WIDTH_U  = decoder_ctrl_pkg::GRID_WIDTH_U,
    parameter int MAXIMUM_DELAY = 3,
    parameter int FIFO_DEPTH    = 8,
    localparam int PE_COUNT     = GRID_WIDTH_X * GRID_WIDTH_Z * GRID_WIDTH_U,
    localparam int CORR_BITS    = correction_bits(GRID_WIDTH_X, GRID_WIDTH_Z),
    localparam int RESULT_BITS  = result_bits(GRID_WIDTH_X, GRID_WIDTH_Z),
    localparam int U_BITS       = field_bits(GRID_WIDTH_U)
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  ctrl_msg_t                            ctrl_rx,
    input  logic                                 ctrl_rx_valid,
    output logic                                 ctrl_rx_ready,
    input  logic [31:0]                          meas_data,
    input  logic                                 meas_valid,
    output logic                                 meas_ready,
    output ctrl_msg_t                            ctrl_tx,
    output logic                                 ctrl_tx_valid,
    input  logic                                 ctrl_tx_ready,
    output logic [31:0]                          out_data,
    output logic                                 out_valid,
    input  logic                                 out_ready,
    input  logic [PE_COUNT-1:0]                  busy_pe,
    input  logic [PE_COUNT-1:0]                  odd_clusters_pe,
    input  logic [CORR_BITS-1:0]                 correction,
    output stage_t                               stage,
    output logic [GRID_WIDTH_X*GRID_WIDTH_Z-1:0] measurements,
    output logic                                 reset_all_edges,
    output logic [U_BITS-1:0]                    result_round
);

    logic                   load_done;
    logic                   push;
    logic [RESULT_BITS-1:0] push_data;
    logic [RESULT_BITS-1:0] pop_data;
    logic                   pop_valid;
    logic                   pop_ready;

    measurement_loader #(
        .GRID_WIDTH_X(GRID_WIDTH_X),
        .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .GRID_WIDTH_U(GRID_WIDTH_U)
    ) loader (
        .clk(clk),
        .reset(reset),
        .stage(stage),
        .meas_data(meas_data),
        .meas_valid(meas_valid),
        .meas_ready(meas_ready),
        .measurements(measurements),
        .reset_all_edges(reset_all_edges),
        .load_done(load_done)
    );

    stage_sequencer #(
        .GRID_WIDTH_X(GRID_WIDTH_X),
        .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .GRID_WIDTH_U(GRID_WIDTH_U),
        .MAXIMUM_DELAY(MAXIMUM_DELAY)
    ) sequencer (
        .clk(clk),
        .reset(reset),
        .ctrl_rx(ctrl_rx),
        .ctrl_rx_valid(ctrl_rx_valid),
        .ctrl_rx_ready(ctrl_rx_ready),
        .ctrl_tx(ctrl_tx),
        .ctrl_tx_valid(ctrl_tx_valid),
        .ctrl_tx_ready(ctrl_tx_ready),
        .load_done(load_done),
        .busy_pe(busy_pe),
        .odd_clusters_pe(odd_clusters_pe),
        .correction(correction),
        .stage(stage),
        .result_round(result_round),
        .push_data(push_data),
        .push(push)
    );

    // holds the summary plus one word per round
    result_fifo #(
        .WIDTH(RESULT_BITS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) result_buffer (
        .clk(clk),
        .reset(reset),
        .push_data(push_data),
        .push(push),
        .pop_data(pop_data),
        .pop_valid(pop_valid),
        .pop_ready(pop_ready)
    );

    correction_serializer #(
        .GRID_WIDTH_U(GRID_WIDTH_U),
        .WIDTH(RESULT_BITS)
    ) serializer (
        .clk(clk),
        .reset(reset),
        .pop_data(pop_data),
        .pop_valid(pop_valid),
        .pop_ready(pop_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

/* tb/decoder_ctrl_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module decoder_ctrl_sva
    import decoder_ctrl_pkg::*;
#(
    parameter int GRID_WIDTH_U = decoder_ctrl_pkg::GRID_WIDTH_U
) (
    input logic   clk,
    input logic   reset,
    input stage_t stage,
    input logic   ctrl_rx_valid,
    input logic   ctrl_rx_ready,
    input logic   ctrl_tx_valid,
    input logic   ctrl_tx_ready,
    input logic   push
);

    // idle is left only on a message taken while ready
    idle_exit_on_accept: assert property (@(posedge clk) disable iff (reset)
        stage == STAGE_IDLE && !(ctrl_rx_valid && ctrl_rx_ready) |=> stage == STAGE_IDLE)
        else $error("stage left idle without an accepted message");

    tx_valid_held: assert property (@(posedge clk) disable iff (reset)
        ctrl_tx_valid && !ctrl_tx_ready |=> ctrl_tx_valid)
        else $error("ctrl_tx_valid dropped before accepted");

    // last correction lands on the idle cycle after GRID_WIDTH_U result cycles
    push_in_result: assert property (@(posedge clk) disable iff (reset)
        push && stage != STAGE_RESULT_VALID |-> stage == STAGE_IDLE
            && $past(stage, GRID_WIDTH_U) == STAGE_RESULT_VALID
            && $past(stage, GRID_WIDTH_U + 1) == STAGE_PEELING)
        else $error("push outside result_valid");

endmodule

bind stage_sequencer decoder_ctrl_sva #(.GRID_WIDTH_U(GRID_WIDTH_U)) sva_checks (.*);

`default_nettype wire

/* tb/tb_decoder_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_decoder_ctrl
    import decoder_ctrl_pkg::*;
;

    localparam int CYCLE = 8;
    localparam int NUM_BLOCKS = 4;
    localparam int RECORD = 16;
    localparam int TIMEOUT_CYCLES = 40 + NUM_BLOCKS * 400;

    logic        clk;
    logic        reset;
    ctrl_msg_t   ctrl_rx;
    logic        ctrl_rx_valid;
    logic        ctrl_rx_ready;
    logic [31:0] meas_data;
    logic        meas_valid;
    logic        meas_ready;
    ctrl_msg_t   ctrl_tx;
    logic        ctrl_tx_valid;
    logic        ctrl_tx_ready;
    logic [31:0] out_data;
    logic        out_valid;
    logic        out_ready;
    logic [11:0] busy_pe;
    logic [11:0] odd_clusters_pe;
    logic [10:0] correction;
    stage_t      stage;
    logic [3:0]  measurements;
    logic        reset_all_edges;
    logic [1:0]  result_round;

    logic [31:0] stim [0:NUM_BLOCKS*RECORD-1];
    logic [31:0] lcg_state = 32'd57515;
    logic [31:0] got_words[$];
    ctrl_msg_t   tx_msg;
    int          tx_count;
    int          odd_merges;
    int          grows;
    int          busy_left;
    int          active_cycles;
    int          result_index;
    logic        odd_flag;
    logic [10:0] corr_table [3];
    int          test_errors;
    int          passed;
    int          failed;

    decoder_ctrl UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CYCLE / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got %0h expected %0h", name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: fail, %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    // graph model, ready randomization and input drive after each edge
    initial begin
        forever begin
            @(posedge clk);
            #1;
            lcg_state = next_rand(lcg_state);
            out_ready = (lcg_state[17:16] != 2'b00);
            ctrl_tx_ready = lcg_state[20];
            if (stage == STAGE_GROW) begin
                grows++;
                busy_left = 2;
                odd_flag = (grows <= odd_merges);
            end else if (busy_left > 0) begin
                busy_left--;
            end
            // decoding stages between idle and result_valid
            if (stage != STAGE_IDLE && stage != STAGE_RESULT_VALID) begin
                active_cycles++;
            end
            if (stage == STAGE_RESULT_VALID) begin
                check_value("result_round", 64'(result_round), 64'(result_index));
                result_index++;
            end else begin
                result_index = 0;
            end
            busy_pe = (busy_left > 0) ? 12'h010 : 12'h000;
            odd_clusters_pe = odd_flag ? 12'h020 : 12'h000;
            correction = (result_round < 3) ? corr_table[result_round] : '0;
        end
    end

    // output capture where the handshake is stable
    initial begin
        forever begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                got_words.push_back(out_data);
            end
            if (ctrl_tx_valid && ctrl_tx_ready) begin
                tx_msg = ctrl_tx;
                tx_count++;
            end
        end
    end

    task automatic send_ctrl(input header_t header, input logic [47:0] payload);
        @(posedge clk);
        #1;
        ctrl_rx = '{dest: 8'h00, header: header, payload: payload};
        ctrl_rx_valid = 1'b1;
        @(negedge clk);
        while (!ctrl_rx_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        ctrl_rx_valid = 1'b0;
    endtask

    task automatic load_measurements(input int base);
        logic [31:0] words[$];
        logic [3:0]  mask;
        int          r;
        logic        check_pending;
        logic        take;
        for (int u = 0; u < 3; u++) begin
            mask = stim[base + 1 + u][3:0];
            for (int x = 0; x < 4; x++) begin
                if (mask[x]) begin
                    words.push_back(32'(u * 8 + x * 2));
                end
            end
        end
        words.push_back(END_MARKER);
        r = 0;
        check_pending = 1'b0;
        meas_data = words[0];
        meas_valid = 1'b1;
        while (words.size() > 0) begin
            @(negedge clk);
            if (check_pending) begin
                check_value("measurements", 64'(measurements), 64'(stim[base + r][3:0]));
                check_pending = 1'b0;
            end
            if (stage == STAGE_MEASUREMENT_LOADING) begin
                check_value("reset_all_edges", 64'(reset_all_edges), 64'd1);
                // word of the current round, or the end marker after the last round
                take = (words[0] == END_MARKER) ? (r == 2) : (words[0][4:3] == r);
                check_value("meas_ready", 64'(meas_ready), 64'(take));
                // round closes on a later round's word or on the end marker
                if (!take || words[0] == END_MARKER) begin
                    check_pending = 1'b1;
                    r++;
                end
                if (meas_ready) begin
                    void'(words.pop_front());
                end
            end
            @(posedge clk);
            #1;
            meas_valid = (words.size() > 0);
            meas_data = (words.size() > 0) ? words[0] : 32'h0;
        end
        @(negedge clk);
        check_value("measurements", 64'(measurements), 64'(stim[base + r][3:0]));
    endtask

    task automatic run_block(input int b);
        int base;
        int count;
        base = b * RECORD;
        odd_merges = int'(stim[base]);
        grows = 0;
        for (int u = 0; u < 3; u++) begin
            corr_table[u] = stim[base + 4 + u][10:0];
        end
        got_words.delete();
        tx_count = 0;
        active_cycles = 0;
        send_ctrl(HEADER_DECODE_BLOCK, 48'h1);
        load_measurements(base);
        while (!(got_words.size() > 0 && got_words[$] == END_MARKER && tx_count > 0
                 && stage == STAGE_IDLE)) begin
            @(negedge clk);
        end
        count = int'(stim[base + 7]);
        check_value("word_count", 64'(got_words.size()), 64'(count + 2));
        check_value("iterations", 64'(got_words[0][31:16]), 64'(odd_merges + 1));
        // plus the cycle that carries the decode message
        check_value("cycles", 64'(got_words[0][15:0]), 64'(active_cycles + 1));
        check_value("ctrl_tx.header", 64'(tx_msg.header), 64'(HEADER_RESULT));
        check_value("ctrl_tx.cycles", 64'(tx_msg.payload[15:0]), 64'(active_cycles + 1));
        check_value("tx_count", 64'(tx_count), 64'd1);
        for (int i = 0; i < count && i + 1 < got_words.size(); i++) begin
            check_value("out_data", 64'(got_words[i + 1]), 64'(stim[base + 8 + i]));
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CYCLE);
        $display("timeout: the run did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        ctrl_rx = '0;
        ctrl_rx_valid = 1'b0;
        ctrl_tx_ready = 1'b0;
        meas_data = '0;
        meas_valid = 1'b0;
        out_ready = 1'b0;
        busy_pe = '0;
        odd_clusters_pe = '0;
        correction = '0;
        odd_flag = 1'b0;
        busy_left = 0;
        grows = 0;
        odd_merges = 0;
        active_cycles = 0;
        result_index = 0;
        tx_count = 0;
        test_errors = 0;
        passed = 0;
        failed = 0;
        corr_table = '{default: '0};
        $readmemh("tb/decoder_stimulus.txt", stim);
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        check_value("stage", 64'(stage), 64'(STAGE_IDLE));
        check_value("ctrl_rx_ready", 64'(ctrl_rx_ready), 64'd1);
        check_value("ctrl_tx_valid", 64'(ctrl_tx_valid), 64'd0);
        check_value("out_valid", 64'(out_valid), 64'd0);
        send_ctrl(HEADER_INITIALIZE_DECODING, 48'h0);
        @(negedge clk);
        check_value("stage", 64'(stage), 64'(STAGE_PARAMETERS_LOADING));
        @(negedge clk);
        check_value("stage", 64'(stage), 64'(STAGE_IDLE));
        check_value("ctrl_rx_ready", 64'(ctrl_rx_ready), 64'd1);
        check_value("ctrl_tx_valid", 64'(ctrl_tx_valid), 64'd0);
        check_value("out_valid", 64'(out_valid), 64'd0);
        close_test("reset_and_initialize");

        for (int b = 0; b < NUM_BLOCKS; b++) begin
            run_block(b);
            close_test($sformatf("block_%0d", b));
        end

        $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* decoder_ctrl.f */
rtl/decoder_ctrl_pkg.sv
rtl/measurement_loader.sv
rtl/stage_sequencer.sv
rtl/result_fifo.sv
rtl/correction_serializer.sv
rtl/decoder_ctrl.sv
tb/decoder_ctrl_sva.sv
tb/tb_decoder_ctrl.sv

/* Makefile */
# Verilator simulation of the decoder stage controller

VERILATOR ?= verilator
TOP       ?= tb_decoder_ctrl
FILELIST  ?= decoder_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "simulation incomplete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/decoder_stimulus.txt */
// per block: odd_merges defects_r0 defects_r1 defects_r2 corr_r0 corr_r1 corr_r2
//            word_count word0 .. word7 (address words before the end marker)
0 3 0 8 005 000 400 3 00 02 4a 0 0 0 0 0
2 0 6 1 001 180 000 3 00 27 28 0 0 0 0 0
1 f 0 0 000 000 003 2 40 41 0 0 0 0 0 0
0 0 0 0 000 000 000 0 0 0 0 0 0 0 0 0
